// File: design/cpu_registers.sv
/* CPU registers
   Holds PC, X, Y and SP and selects the fetcher's data source */
module cpu_registers (
        input  logic                                 instruction_done,
        input  logic                                 reset_n,
        input  fetch_bus_pkg::reg_load_t             reg_load,
        input  logic                                 pc_advance,
        input  logic [fetch_bus_pkg::addr_width-1:0] pc_next,
        input  fetch_bus_pkg::data_sel_t             data_sel,
        input  logic [fetch_bus_pkg::reg_width-1:0]  mem_data,
        output logic [fetch_bus_pkg::addr_width-1:0] pc,
        output logic [fetch_bus_pkg::reg_width-1:0]  data_in
);
        import fetch_bus_pkg::*;

        logic [reg_width-1:0] x_reg;
        logic [reg_width-1:0] y_reg;
        logic [reg_width-1:0] sp_reg;

        always_ff @(posedge instruction_done) begin
                if (!reset_n) begin
                        pc <= instruction_base;
                        x_reg <= '0;
                        y_reg <= '0;
                        sp_reg <= '0;
                end else begin
                        if (pc_advance)
                                pc <= pc_next;      // Past the finished instruction
                        if (reg_load.load_x)
                                x_reg <= reg_load.value;
                        if (reg_load.load_y)
                                y_reg <= reg_load.value;
                        if (reg_load.load_sp)
                                sp_reg <= reg_load.value;
                end
        end

        // Index cycles read X or Y in place of memory
        always_comb begin
                case (data_sel)
                        sel_mem: data_in = mem_data;
                        sel_x:   data_in = x_reg;
                        sel_y:   data_in = y_reg;
                        default: data_in = sp_reg;  // Spare code reads SP
                endcase
        end

endmodule

// File: design/fetch_bus_pkg.sv
/* Fetch bus definitions
   Widths, reset vector, data source select and the fetch unit's port records */
package fetch_bus_pkg;

        localparam int addr_width = 16;
        localparam int reg_width = 8;

        localparam logic [addr_width-1:0] instruction_base = 16'h0200;   // PC after reset

        // Source of the fetcher's data input
        typedef enum logic [1:0] {
                sel_mem = 2'd0,
                sel_x   = 2'd1,
                sel_y   = 2'd2
        } data_sel_t;

        typedef struct packed {
                logic [addr_width-1:0] addr;
        } mem_req_t;

        // Register write port, one load strobe per register
        typedef struct packed {
                logic                 load_x;
                logic                 load_y;
                logic                 load_sp;
                logic [reg_width-1:0] value;
        } reg_load_t;

        typedef struct packed {
                logic [reg_width-1:0]  opcode;
                logic [addr_width-1:0] ea;
                logic [reg_width-1:0]  imm;
                logic                  has_ea;
                logic [1:0]            length;       // Bytes, opcode included
        } fetch_result_t;

endpackage

// File: design/fetch_unit.sv
/* Instruction fetch unit
   Fetches an opcode and its operands and presents the effective address */
module fetch_unit (
        input  logic                                 instruction_done,
        input  logic                                 reset_n,
        input  logic                                 start,
        input  fetch_bus_pkg::reg_load_t             reg_load,
        input  logic [fetch_bus_pkg::reg_width-1:0]  mem_data,
        output fetch_bus_pkg::mem_req_t              mem_req,
        output logic                                 instruction_ready,
        output fetch_bus_pkg::fetch_result_t         result,
        output logic [fetch_bus_pkg::addr_width-1:0] pc
);
        import mos6502_isa_pkg::*;
        import fetch_bus_pkg::*;

        opcode_t               opcode;
        decoded_t              decoded;
        data_sel_t             data_sel;
        logic [reg_width-1:0]  data_in;
        logic                  pc_advance;
        logic [addr_width-1:0] pc_next;

        opcode_decoder opcode_decoder_i (
                .opcode  (opcode),
                .decoded (decoded)
        );

        operand_fetcher operand_fetcher_i (
                .instruction_done  (instruction_done),
                .reset_n           (reset_n),
                .start             (start),
                .opcode            (opcode),
                .decoded           (decoded),
                .pc                (pc),
                .data_in           (data_in),
                .data_sel          (data_sel),
                .mem_req           (mem_req),
                .pc_advance        (pc_advance),
                .pc_next           (pc_next),
                .instruction_ready (instruction_ready),
                .result            (result)
        );

        cpu_registers cpu_registers_i (
                .instruction_done (instruction_done),
                .reset_n          (reset_n),
                .reg_load         (reg_load),
                .pc_advance       (pc_advance),
                .pc_next          (pc_next),
                .data_sel         (data_sel),
                .mem_data         (mem_data),
                .pc               (pc),
                .data_in          (data_in)
        );

endmodule

// File: design/mos6502_isa_pkg.sv
/* 6502 instruction set definitions
   Opcode layout, addressing modes and the decoder's output record */
package mos6502_isa_pkg;

        // Opcode byte as aaa bbb cc
        typedef struct packed {
                logic [2:0] aaa;
                logic [2:0] bbb;
                logic [1:0] cc;
        } opcode_fields_t;

        // Matched as a whole byte or by field groups
        typedef union packed {
                logic [7:0]     raw;
                opcode_fields_t fields;
        } opcode_t;

        typedef enum logic [2:0] {
                am_implied   = 3'd0,
                am_immediate = 3'd1,
                am_relative  = 3'd2,
                am_zpg       = 3'd3,
                am_zpg_x     = 3'd4,
                am_abs       = 3'd5,
                am_abs_x     = 3'd6,
                am_abs_y     = 3'd7
        } addr_mode_t;

        // Instruction groups by cc
        localparam logic [1:0] cc_ctrl = 2'b00;
        localparam logic [1:0] cc_alu = 2'b01;
        localparam logic [1:0] cc_rmw = 2'b10;

        // LDX and STX in the aaa field, upper two bits
        localparam logic [1:0] aaa_x_xfer = 2'b10;
        localparam logic [2:0] aaa_ldx = 3'b101;

        // Whole opcodes outside the column rules
        localparam logic [7:0] op_jsr = 8'h20;
        localparam logic [7:0] op_ldy_imm = 8'hA0;
        localparam logic [7:0] op_ldx_imm = 8'hA2;
        localparam logic [7:0] op_cpy_imm = 8'hC0;
        localparam logic [7:0] op_cpx_imm = 8'hE0;

        typedef struct packed {
                addr_mode_t               mode;
                logic [1:0]               operand_bytes;
                fetch_bus_pkg::data_sel_t index_sel;     // sel_mem when not indexed
        } decoded_t;

endpackage

// File: design/opcode_decoder.sv
/* Opcode decoder
   Classifies an opcode into addressing mode, operand length and index register */
module opcode_decoder (
        input  mos6502_isa_pkg::opcode_t  opcode,
        output mos6502_isa_pkg::decoded_t decoded
);
        import mos6502_isa_pkg::*;
        import fetch_bus_pkg::*;

        addr_mode_t mode;
        logic       zpg_y;

        // Column rules first, then whole-opcode exceptions
        always_comb begin
                mode = am_implied;
                case (opcode.fields.cc)
                        cc_alu: begin
                                case (opcode.fields.bbb)
                                        3'b001:  mode = am_zpg;
                                        3'b010:  mode = am_immediate;
                                        3'b011:  mode = am_abs;
                                        3'b101:  mode = am_zpg_x;
                                        3'b110:  mode = am_abs_y;
                                        3'b111:  mode = am_abs_x;
                                        default: mode = am_implied;  // Indirect forms not handled
                                endcase
                        end
                        cc_ctrl: begin
                                case (opcode.fields.bbb)
                                        3'b001:  mode = am_zpg;
                                        3'b011:  mode = am_abs;
                                        3'b100:  mode = am_relative;  // Branches
                                        3'b101:  mode = am_zpg_x;
                                        3'b111:  mode = am_abs_x;
                                        default: mode = am_implied;   // TYA, CLC, SEC ...
                                endcase
                        end
                        cc_rmw: begin
                                case (opcode.fields.bbb)
                                        3'b001:  mode = am_zpg;
                                        3'b011:  mode = am_abs;
                                        3'b101:  mode = am_zpg_x;
                                        3'b111: begin
                                                // LDX abs indexes with Y
                                                if (opcode.fields.aaa == aaa_ldx)
                                                        mode = am_abs_y;
                                                else
                                                        mode = am_abs_x;
                                        end
                                        default: mode = am_implied;   // Accumulator, TXS, TSX
                                endcase
                        end
                        default: mode = am_implied;
                endcase

                case (opcode.raw)
                        op_jsr:     mode = am_abs;
                        op_ldy_imm,
                        op_ldx_imm,
                        op_cpy_imm,
                        op_cpx_imm: mode = am_immediate;
                        default: ;
                endcase
        end

        // STX and LDX zero page index with Y
        assign zpg_y = (opcode.fields.cc == cc_rmw) && (opcode.fields.aaa[2:1] == aaa_x_xfer);

        always_comb begin
                decoded.mode = mode;
                case (mode)
                        am_implied:   decoded.operand_bytes = 2'd0;
                        am_immediate,
                        am_relative,
                        am_zpg,
                        am_zpg_x:     decoded.operand_bytes = 2'd1;
                        default:      decoded.operand_bytes = 2'd2;
                endcase
                case (mode)
                        am_zpg_x: decoded.index_sel = zpg_y ? sel_y : sel_x;
                        am_abs_x: decoded.index_sel = sel_x;
                        am_abs_y: decoded.index_sel = sel_y;
                        default:  decoded.index_sel = sel_mem;
                endcase
        end

endmodule

// File: design/operand_fetcher.sv
/* Operand fetcher
   Sequences opcode, operand and index cycles and forms the effective address */
module operand_fetcher (
        input  logic                                       instruction_done,
        input  logic                                       reset_n,
        input  logic                                       start,
        output mos6502_isa_pkg::opcode_t                   opcode,
        input  mos6502_isa_pkg::decoded_t                  decoded,
        input  logic [fetch_bus_pkg::addr_width-1:0]       pc,
        input  logic [fetch_bus_pkg::reg_width-1:0]        data_in,
        output fetch_bus_pkg::data_sel_t                   data_sel,
        output fetch_bus_pkg::mem_req_t                    mem_req,
        output logic                                       pc_advance,
        output logic [fetch_bus_pkg::addr_width-1:0]       pc_next,
        output logic                                       instruction_ready,
        output fetch_bus_pkg::fetch_result_t               result
);
        import mos6502_isa_pkg::*;
        import fetch_bus_pkg::*;

        typedef enum logic [2:0] {
                st_idle,
                st_opcode,
                st_operand_lo,
                st_operand_hi,
                st_index,
                st_done
        } fetch_state_t;

        fetch_state_t          state;
        fetch_state_t          state_nxt;
        logic [1:0]            fetch_count;    // Byte offset from pc
        opcode_t               opcode_q;
        logic [addr_width-1:0] addr_q;         // Operand bytes, then indexed address
        logic                  indexed;
        logic                  finish;
        logic [1:0]            length;
        logic                  has_ea;

        assign indexed = decoded.index_sel != sel_mem;
        assign length = decoded.operand_bytes + 2'd1;

        always_comb begin
                state_nxt = state;
                finish = 1'b0;
                case (state)
                        st_idle,
                        st_done: begin
                                state_nxt = start ? st_opcode : st_idle;  // Busy states ignore start
                        end
                        st_opcode: begin
                                if (decoded.operand_bytes == 2'd0)
                                        finish = 1'b1;
                                else
                                        state_nxt = st_operand_lo;
                        end
                        st_operand_lo: begin
                                if (decoded.operand_bytes == 2'd2)
                                        state_nxt = st_operand_hi;
                                else if (indexed)
                                        state_nxt = st_index;
                                else
                                        finish = 1'b1;
                        end
                        st_operand_hi: begin
                                if (indexed)
                                        state_nxt = st_index;
                                else
                                        finish = 1'b1;
                        end
                        st_index: finish = 1'b1;
                        default:  state_nxt = st_idle;
                endcase
                if (finish)
                        state_nxt = st_done;
        end

        always_ff @(posedge instruction_done) begin
                if (!reset_n) begin
                        state <= st_idle;
                        fetch_count <= 2'd0;
                end else begin
                        state <= state_nxt;
                        if (state_nxt == st_opcode)
                                fetch_count <= 2'd0;
                        else if (state_nxt == st_operand_lo || state_nxt == st_operand_hi)
                                fetch_count <= fetch_count + 2'd1;
                end
        end

        always_ff @(posedge instruction_done) begin
                case (state)
                        st_opcode:     opcode_q.raw <= data_in;
                        st_operand_lo: addr_q <= {8'h00, data_in};
                        st_operand_hi: addr_q[15:8] <= data_in;
                        st_index: begin
                                // Zero page indexing wraps inside page zero
                                if (decoded.mode == am_zpg_x)
                                        addr_q[7:0] <= addr_q[7:0] + data_in;
                                else
                                        addr_q <= addr_q + {8'h00, data_in};
                        end
                        default: ;
                endcase
        end

        // Decoder sees the byte on the bus until it is latched
        always_comb begin
                opcode = opcode_q;
                if (state == st_opcode)
                        opcode.raw = data_in;
        end

        assign mem_req.addr = pc + {14'd0, fetch_count};
        assign data_sel = (state == st_index) ? decoded.index_sel : sel_mem;

        assign pc_advance = finish;
        assign pc_next = pc + {14'd0, length};
        assign instruction_ready = state == st_done;

        assign has_ea = decoded.mode inside {am_zpg, am_zpg_x, am_abs, am_abs_x, am_abs_y};

        always_comb begin
                result.opcode = opcode_q.raw;
                result.has_ea = has_ea;
                result.length = length;
                result.ea = has_ea ? addr_q : '0;
                if (decoded.mode == am_immediate || decoded.mode == am_relative)
                        result.imm = addr_q[7:0];
                else
                        result.imm = '0;
        end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the fetch unit testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_fetch_unit -f src.f -o tb_fetch_unit \
        && ./obj_dir/tb_fetch_unit > sim.log 2>&1 \
        || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "test failed" sim.log && { echo "Simulation reported a failure"; exit 1; }
echo "Simulation finished without failures"
exit 0

// File: src.f
design/fetch_bus_pkg.sv
design/mos6502_isa_pkg.sv
design/opcode_decoder.sv
design/operand_fetcher.sv
design/cpu_registers.sv
design/fetch_unit.sv
verification/fetch_checker.sv
verification/tb_fetch_unit.sv

// File: verification/fetch_checker.sv
/* Fetch checker
   Compares each finished fetch and the new pc with the expected values */
module fetch_checker (
        input  logic                                 instruction_done,
        input  logic                                 reset_n,
        input  logic                                 start,
        input  logic                                 instruction_ready,
        input  fetch_bus_pkg::fetch_result_t         result,
        input  logic [fetch_bus_pkg::addr_width-1:0] pc,
        input  fetch_bus_pkg::fetch_result_t         expected,
        output int                                   checked_count,
        output int                                   error_count
);
        import fetch_bus_pkg::*;

        localparam int ready_limit = 6;        // Cycles from start to instruction_ready

        logic                  waiting = 1'b0;
        int                    wait_cycles = 0;
        int                    case_errors = 0;
        logic [addr_width-1:0] exp_pc = instruction_base;
        logic [addr_width-1:0] next_pc;
        logic                  want_ea;

        initial begin
                checked_count = 0;
                error_count = 0;
        end

        task automatic mismatch(input string what, input logic [15:0] got,
                                input logic [15:0] want);
                $display("FAIL @%0t: case %0d %s is %h, expected %h",
                         $time, checked_count + 1, what, got, want);
                case_errors++;
        endtask

        task automatic close_case();
                if (case_errors == 0) begin
                        $display("case %0d ok: opcode %h, length %0d, pc %h",
                                 checked_count + 1, result.opcode, result.length, pc);
                end else begin
                        $display("case %0d: %0d mismatches", checked_count + 1, case_errors);
                        error_count++;
                end
                waiting = 1'b0;
                checked_count++;
        endtask

        // Sampled mid-cycle, away from the clock edge
        always @(negedge instruction_done) begin
                next_pc = exp_pc + {14'd0, expected.length};
                if (!reset_n) begin
                        waiting = 1'b0;
                        exp_pc = instruction_base;
                end else if (!waiting) begin
                        if (start) begin
                                waiting = 1'b1;
                                wait_cycles = 0;
                                case_errors = 0;
                                if (pc !== exp_pc)
                                        mismatch("pc at start", pc, exp_pc);
                        end
                end else if (instruction_ready) begin
                        // Implied one-byte instructions never carry an address
                        want_ea = expected.has_ea && expected.length != 2'd1;
                        if (result.opcode !== expected.opcode)
                                mismatch("opcode", {8'h00, result.opcode},
                                         {8'h00, expected.opcode});
                        if (result.has_ea !== want_ea)
                                mismatch("has_ea", {15'd0, result.has_ea}, {15'd0, want_ea});
                        if (result.length !== expected.length)
                                mismatch("length", {14'd0, result.length},
                                         {14'd0, expected.length});
                        if (want_ea && result.ea !== expected.ea)
                                mismatch("ea", result.ea, expected.ea);
                        // Immediate and relative byte
                        if (!want_ea && expected.length == 2'd2 &&
                            result.imm !== expected.imm)
                                mismatch("imm", {8'h00, result.imm}, {8'h00, expected.imm});
                        if (pc !== next_pc)
                                mismatch("pc after fetch", pc, next_pc);
                        exp_pc = next_pc;
                        close_case();
                end else begin
                        wait_cycles++;
                        if (wait_cycles > ready_limit) begin
                                $display("Case %0d got no instruction_ready within %0d cycles",
                                         checked_count + 1, ready_limit);
                                case_errors++;
                                close_case();
                        end
                end
        end

endmodule

// File: verification/fetch_stimulus.txt
// x  y  opcode op1 op2 ea imm has_ea length (hex, one case per line)
// ea is checked when has_ea is 1, imm for two-byte instructions without ea
00 00 18 00 00 0000 00 1 1
00 00 a9 5c 00 0000 5c 0 2
00 00 a2 c3 00 0000 c3 0 2
00 00 f0 fa 00 0000 fa 0 2
00 00 a5 42 00 0042 00 1 2
00 00 ad 34 12 1234 00 1 3
05 00 95 80 00 0085 00 1 2
f0 00 b5 20 00 0010 00 1 2
20 00 bd f0 12 1310 00 1 3
00 01 b9 ff 30 3100 00 1 3
7f 81 be c0 44 4541 00 1 3
00 00 e8 00 00 0000 00 0 1
00 00 20 00 80 8000 00 1 3
00 00 a0 07 00 0000 07 0 2
00 00 c9 99 00 0000 99 0 2
00 00 d0 10 00 0000 10 0 2
00 00 86 ff 00 00ff 00 1 2
ff 00 fe 01 20 2100 00 1 3
10 00 b4 f8 00 0008 00 1 2
00 00 98 00 00 0000 00 0 1
00 00 0e 78 56 5678 00 1 3
00 00 38 00 00 0000 00 0 1
00 00 e0 40 00 0000 40 0 2
00 ff b9 01 7f 8000 00 1 3
80 00 75 80 00 0000 00 1 2
00 00 ea 00 00 0000 00 0 1

// File: verification/tb_fetch_unit.sv
/* Fetch unit testbench
   Runs the cases of the stimulus file through the fetch unit */
module tb_fetch_unit;
        import fetch_bus_pkg::*;

        localparam int fields = 9;             // x y opcode op1 op2 ea imm has_ea length
        localparam int max_cases = 64;
        localparam logic [15:0] no_case = 16'hffff;

        logic                  instruction_done;
        logic                  reset_n;
        logic                  start;
        reg_load_t             reg_load;
        logic [reg_width-1:0]  mem_data;
        mem_req_t              mem_req;
        logic                  instruction_ready;
        fetch_result_t         result;
        logic [addr_width-1:0] pc;
        fetch_result_t         expected;
        int                    checked_count;
        int                    error_count;
        int                    num_cases;
        int                    cycle_count = 0;
        int                    cycle_limit = 40;

        logic [reg_width-1:0]  memory [0:65535];
        logic [15:0]           stimulus [0:fields*max_cases-1];

        assign mem_data = memory[mem_req.addr];     // Asynchronous read

        fetch_unit fetch_unit_i (
                .instruction_done  (instruction_done),
                .reset_n           (reset_n),
                .start             (start),
                .reg_load          (reg_load),
                .mem_data          (mem_data),
                .mem_req           (mem_req),
                .instruction_ready (instruction_ready),
                .result            (result),
                .pc                (pc)
        );

        fetch_checker fetch_checker_i (
                .instruction_done  (instruction_done),
                .reset_n           (reset_n),
                .start             (start),
                .instruction_ready (instruction_ready),
                .result            (result),
                .pc                (pc),
                .expected          (expected),
                .checked_count     (checked_count),
                .error_count       (error_count)
        );

        always #50 instruction_done = ~instruction_done;

        always @(posedge instruction_done) begin
                cycle_count++;
                if (cycle_count > cycle_limit) begin
                        $display("Timeout: %0d cycles passed and not every case finished", cycle_limit);
                        $display("test failed");
                        $finish;
                end
        end

        function automatic reg_load_t make_load(input logic to_x, input logic to_y,
                                                input logic [7:0] value);
                reg_load_t word;
                word = '0;
                word.load_x = to_x;
                word.load_y = to_y;
                word.value = value;
                return word;
        endfunction

        function automatic int count_cases();
                int n;
                n = 0;
                while (n < max_cases && stimulus[n * fields + 8] != no_case)
                        n++;
                return n;
        endfunction

        task automatic fill_memory();
                logic [15:0] addr;
                for (int a = 0; a < 65536; a++) begin
                        addr = a[15:0];
                        memory[a] = addr[15:8] ^ addr[7:0] ^ 8'h3c;
                end
        endtask

        task automatic run_case(input int n);
                int          base;
                logic [15:0] at;
                base = n * fields;
                @(posedge instruction_done);
                reg_load <= make_load(1'b1, 1'b0, stimulus[base][7:0]);
                @(posedge instruction_done);
                reg_load <= make_load(1'b0, 1'b1, stimulus[base + 1][7:0]);
                @(posedge instruction_done);
                reg_load <= '0;
                at = pc;
                memory[at] = stimulus[base + 2][7:0];
                memory[at + 16'd1] = stimulus[base + 3][7:0];
                memory[at + 16'd2] = stimulus[base + 4][7:0];
                expected.opcode <= stimulus[base + 2][7:0];
                expected.ea <= stimulus[base + 5];
                expected.imm <= stimulus[base + 6][7:0];
                expected.has_ea <= stimulus[base + 7][0];
                expected.length <= stimulus[base + 8][1:0];
                start <= 1'b1;
                @(posedge instruction_done);
                start <= 1'b0;
                if (stimulus[base + 8][1:0] == 2'd3) begin
                        // Second pulse arrives mid-fetch
                        @(posedge instruction_done);
                        start <= 1'b1;
                        @(posedge instruction_done);
                        start <= 1'b0;
                end
                while (checked_count <= n)
                        @(posedge instruction_done);
        endtask

        initial begin
                instruction_done = 1'b0;
                reset_n = 1'b0;
                start = 1'b0;
                reg_load = '0;
                expected = '0;
                fill_memory();
                for (int i = 0; i < fields * max_cases; i++)
                        stimulus[i] = no_case;
                $readmemh("verification/fetch_stimulus.txt", stimulus);
                num_cases = count_cases();
                cycle_limit = num_cases * 12 + 40;
                repeat (16) @(posedge instruction_done);
                reset_n <= 1'b1;
                for (int n = 0; n < num_cases; n++)
                        run_case(n);
                repeat (2) @(posedge instruction_done);
                $display("Summary: %0d cases, %0d checked, %0d with errors",
                         num_cases, checked_count, error_count);
                if (num_cases > 0 && error_count == 0 && checked_count == num_cases) begin
                        $display("test passed");
                end else begin
                        if (num_cases == 0)
                                $display("No cases were read from the stimulus file");
                        $display("test failed");
                end
                $finish;
        end

endmodule
